// ==== AudioDmaPkg.sv ====
// Shared widths, register map and limits for the audio playback DMA
// Referenced by scoped name from the RTL and the testbench

package AudioDmaPkg;

	//------------------------------------------------------------
	// Bus and data widths
	//------------------------------------------------------------
	// Memory word address, also start and length width
	localparam int MemAdrsWidth = 19;
	// One audio sample per memory word
	localparam int SmpWidth = 16;
	// Host side word addressing
	localparam int WbAdrsWidth = 3;
	localparam int WbDataWidth = 32;

	//------------------------------------------------------------
	// Channel and flow limits
	//------------------------------------------------------------
	localparam int ChanCount = 2;
	// Commands per grant before a unit yields
	localparam int BurstMax = 2;
	// Sample FIFO depth, doubles as read credit per channel
	localparam int FifoDepth = 16;
	// Level runs 0 to FifoDepth
	localparam int FifoLevelWidth = 5;

	//------------------------------------------------------------
	// Register map, word addresses
	//------------------------------------------------------------
	// Bit 0 enables channel 0, bit 1 channel 1
	localparam logic [WbAdrsWidth-1:0] RegCtrl = 3'd0;
	localparam logic [WbAdrsWidth-1:0] RegStart0 = 3'd1;
	localparam logic [WbAdrsWidth-1:0] RegLen0 = 3'd2;
	localparam logic [WbAdrsWidth-1:0] RegStart1 = 3'd3;
	localparam logic [WbAdrsWidth-1:0] RegLen1 = 3'd4;

	// Payload types
	typedef logic [SmpWidth-1:0] smpT;
	// Channel number carried with each read
	typedef logic [0:0] tagT;

endpackage

// ==== AudioDmaSubsystem.sv ====
// Two-channel audio playback DMA top level
// Host programs channels over Wishbone, samples leave through show-ahead FIFOs

`timescale 1ns/100ps

module AudioDmaSubsystem (
	input  logic                                  iCLK,
	input  logic                                  iRST,
	// Host register port
	input  logic                                  wbCyc,
	input  logic                                  wbStb,
	input  logic                                  wbWe,
	input  logic [AudioDmaPkg::WbAdrsWidth-1:0]   wbAdr,
	input  logic [AudioDmaPkg::WbDataWidth-1:0]   wbDatW,
	output logic [AudioDmaPkg::WbDataWidth-1:0]   wbDatR,
	output logic                                  wbAck,
	// External memory port
	output logic                                  memCmd,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]  memAdrs,
	input  logic                                  memRdy,
	input  AudioDmaPkg::smpT                      memRd,
	input  logic                                  memREd,
	// Sample streams
	output AudioDmaPkg::smpT                      smpRd0,
	output logic                                  smpVd0,
	input  logic                                  smpRe0,
	output AudioDmaPkg::smpT                      smpRd1,
	output logic                                  smpVd1,
	input  logic                                  smpRe1
);

	logic [AudioDmaPkg::MemAdrsWidth-1:0]   dmaAdrs0;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   dmaLen0;
	logic                                   dmaEn0;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   dmaAdrs1;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   dmaLen1;
	logic                                   dmaEn1;
	logic                                   reqVd0;
	logic                                   reqRdy0;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   reqAdrs0;
	logic                                   reqVd1;
	logic                                   reqRdy1;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   reqAdrs1;
	logic                                   smpWe0;
	logic                                   smpWe1;
	AudioDmaPkg::smpT                       smpWd0;
	AudioDmaPkg::smpT                       smpWd1;
	logic [AudioDmaPkg::FifoLevelWidth-1:0] level0;
	logic [AudioDmaPkg::FifoLevelWidth-1:0] level1;

	//------------------------------------------------------------
	// Register decode
	//------------------------------------------------------------
	DmaRegDecode decode_i (
		.iCLK (iCLK), .iRST (iRST),
		.wbCyc (wbCyc), .wbStb (wbStb), .wbWe (wbWe),
		.wbAdr (wbAdr), .wbDatW (wbDatW), .wbDatR (wbDatR), .wbAck (wbAck),
		.dmaAdrs0 (dmaAdrs0), .dmaLen0 (dmaLen0), .dmaEn0 (dmaEn0),
		.dmaAdrs1 (dmaAdrs1), .dmaLen1 (dmaLen1), .dmaEn1 (dmaEn1)
	);

	//------------------------------------------------------------
	// Read engines, retire driven by the sample write strobe
	//------------------------------------------------------------
	AudioDmaUnit unit0_i (
		.iCLK (iCLK), .iRST (iRST),
		.dmaAdrs (dmaAdrs0), .dmaLen (dmaLen0), .dmaEn (dmaEn0),
		.reqRdy (reqRdy0), .retire (smpWe0), .fifoLevel (level0),
		.reqVd (reqVd0), .reqAdrs (reqAdrs0)
	);

	AudioDmaUnit unit1_i (
		.iCLK (iCLK), .iRST (iRST),
		.dmaAdrs (dmaAdrs1), .dmaLen (dmaLen1), .dmaEn (dmaEn1),
		.reqRdy (reqRdy1), .retire (smpWe1), .fifoLevel (level1),
		.reqVd (reqVd1), .reqAdrs (reqAdrs1)
	);

	// Shared memory port
	MemPortArbiter arb_i (
		.iCLK (iCLK), .iRST (iRST),
		.reqVd0 (reqVd0), .reqAdrs0 (reqAdrs0),
		.reqVd1 (reqVd1), .reqAdrs1 (reqAdrs1),
		.memRdy (memRdy), .memRd (memRd), .memREd (memREd),
		.reqRdy0 (reqRdy0), .reqRdy1 (reqRdy1),
		.memCmd (memCmd), .memAdrs (memAdrs),
		.smpWe0 (smpWe0), .smpWd0 (smpWd0),
		.smpWe1 (smpWe1), .smpWd1 (smpWd1)
	);

	//------------------------------------------------------------
	// Sample queues toward the sinks
	//------------------------------------------------------------
	SampleFifo #(.payloadT (AudioDmaPkg::smpT)) fifo0_i (
		.iCLK (iCLK), .iRST (iRST),
		.wr (smpWe0), .wd (smpWd0), .rd (smpRe0),
		.rdData (smpRd0), .notEmpty (smpVd0), .level (level0)
	);

	SampleFifo #(.payloadT (AudioDmaPkg::smpT)) fifo1_i (
		.iCLK (iCLK), .iRST (iRST),
		.wr (smpWe1), .wd (smpWd1), .rd (smpRe1),
		.rdData (smpRd1), .notEmpty (smpVd1), .level (level1)
	);

endmodule

// ==== AudioDmaUnit.sv ====
// Per-channel read engine walking a looping sample buffer
// Issues read commands under a FIFO credit limit and yields after a burst

`timescale 1ns/100ps

module AudioDmaUnit (
	input  logic                                   iCLK,
	input  logic                                   iRST,
	input  logic [AudioDmaPkg::MemAdrsWidth-1:0]   dmaAdrs,
	input  logic [AudioDmaPkg::MemAdrsWidth-1:0]   dmaLen,
	input  logic                                   dmaEn,
	input  logic                                   reqRdy,
	input  logic                                   retire,
	input  logic [AudioDmaPkg::FifoLevelWidth-1:0] fifoLevel,
	output logic                                   reqVd,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]   reqAdrs
);

	logic                                   active;
	logic                                   accept;
	logic                                   yield;
	logic                                   creditOk;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   offset;
	logic [AudioDmaPkg::MemAdrsWidth-1:0]   offNext;
	logic [AudioDmaPkg::FifoLevelWidth-1:0] outCnt;
	logic [AudioDmaPkg::FifoLevelWidth:0]   creditSum;
	logic [$clog2(AudioDmaPkg::BurstMax)-1:0] burstCnt;

	//------------------------------------------------------------
	// Control decode
	//------------------------------------------------------------
	// Zero length counts as disabled
	assign active = dmaEn & (dmaLen != '0);
	assign accept = reqVd & reqRdy;
	// Last command of this burst
	assign yield = accept & (burstCnt == $bits(burstCnt)'(AudioDmaPkg::BurstMax - 1));

	// Reads in flight plus queued samples, pops ignored so it never undercounts
	// A retire moves one read into the FIFO, so the sum is unchanged by it
	assign creditSum = outCnt + fifoLevel + accept;
	assign creditOk = creditSum < AudioDmaPkg::FifoDepth;

	// Offset walk, back to zero after the last word
	always_comb
	begin
		if (!active)
			offNext = '0;
		else if (accept && (offset == dmaLen - 1'b1))
			offNext = '0;
		else if (accept)
			offNext = offset + 1'b1;
		else
			offNext = offset;
	end

	//------------------------------------------------------------
	// State
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			offset   <= '0;
			burstCnt <= '0;
			reqVd    <= 1'b0;
			outCnt   <= '0;
		end
		else
		begin
			offset <= offNext;

			// Burst counter restarts on yield or disable
			if (!active || yield)
				burstCnt <= '0;
			else if (accept)
				burstCnt <= burstCnt + 1'b1;

			// Held until taken, one idle cycle after a burst
			reqVd <= active & creditOk & ~yield;

			// Outstanding reads survive a disable and drain by retire
			case ({accept, retire})
				2'b10:   outCnt <= outCnt + 1'b1;
				2'b01:   outCnt <= outCnt - 1'b1;
				default: outCnt <= outCnt;
			endcase
		end

		// Address tracks the offset one to one
		reqAdrs <= dmaAdrs + offNext;
	end

endmodule

// ==== DmaRegDecode.sv ====
// Wishbone classic slave holding the per-channel DMA configuration
// Start, length and enable registers feed the read engines directly

`timescale 1ns/100ps

module DmaRegDecode (
	input  logic                                  iCLK,
	input  logic                                  iRST,
	input  logic                                  wbCyc,
	input  logic                                  wbStb,
	input  logic                                  wbWe,
	input  logic [AudioDmaPkg::WbAdrsWidth-1:0]   wbAdr,
	input  logic [AudioDmaPkg::WbDataWidth-1:0]   wbDatW,
	output logic [AudioDmaPkg::WbDataWidth-1:0]   wbDatR,
	output logic                                  wbAck,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]  dmaAdrs0,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]  dmaLen0,
	output logic                                  dmaEn0,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]  dmaAdrs1,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]  dmaLen1,
	output logic                                  dmaEn1
);

	logic                                 wrHit;
	logic [AudioDmaPkg::WbDataWidth-1:0]  rdMux;

	//------------------------------------------------------------
	// Classic handshake
	//------------------------------------------------------------
	// Write lands at the end of the ack cycle
	assign wrHit = wbAck & wbCyc & wbStb & wbWe;

	// Read-back select, unused bits and unmapped words stay zero
	always_comb
	begin
		rdMux = '0;
		case (wbAdr)
			AudioDmaPkg::RegCtrl:   rdMux[1:0] = {dmaEn1, dmaEn0};
			AudioDmaPkg::RegStart0: rdMux[AudioDmaPkg::MemAdrsWidth-1:0] = dmaAdrs0;
			AudioDmaPkg::RegLen0:   rdMux[AudioDmaPkg::MemAdrsWidth-1:0] = dmaLen0;
			AudioDmaPkg::RegStart1: rdMux[AudioDmaPkg::MemAdrsWidth-1:0] = dmaAdrs1;
			AudioDmaPkg::RegLen1:   rdMux[AudioDmaPkg::MemAdrsWidth-1:0] = dmaLen1;
			default:                rdMux = '0;
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		// One ack per strobe, low again after one cycle
		if (iRST)
			wbAck <= 1'b0;
		else
			wbAck <= wbCyc & wbStb & ~wbAck;

		// Data sampled with the ack rising
		wbDatR <= rdMux;
	end

	//------------------------------------------------------------
	// Configuration registers
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			dmaEn0   <= 1'b0;
			dmaEn1   <= 1'b0;
			dmaAdrs0 <= '0;
			dmaLen0  <= '0;
			dmaAdrs1 <= '0;
			dmaLen1  <= '0;
		end
		else if (wrHit)
		begin
			case (wbAdr)
				AudioDmaPkg::RegCtrl:
				begin
					dmaEn0 <= wbDatW[0];
					dmaEn1 <= wbDatW[1];
				end
				AudioDmaPkg::RegStart0: dmaAdrs0 <= wbDatW[AudioDmaPkg::MemAdrsWidth-1:0];
				AudioDmaPkg::RegLen0:   dmaLen0  <= wbDatW[AudioDmaPkg::MemAdrsWidth-1:0];
				AudioDmaPkg::RegStart1: dmaAdrs1 <= wbDatW[AudioDmaPkg::MemAdrsWidth-1:0];
				AudioDmaPkg::RegLen1:   dmaLen1  <= wbDatW[AudioDmaPkg::MemAdrsWidth-1:0];
				// Unmapped writes ignored
				default: ;
			endcase
		end
	end

endmodule

// ==== MemPortArbiter.sv ====
// Round-robin merge of two channel request streams onto one memory port
// A tag FIFO records the channel of each read to steer in-order returns

`timescale 1ns/100ps

module MemPortArbiter (
	input  logic                                  iCLK,
	input  logic                                  iRST,
	input  logic                                  reqVd0,
	input  logic [AudioDmaPkg::MemAdrsWidth-1:0]  reqAdrs0,
	input  logic                                  reqVd1,
	input  logic [AudioDmaPkg::MemAdrsWidth-1:0]  reqAdrs1,
	input  logic                                  memRdy,
	input  AudioDmaPkg::smpT                      memRd,
	input  logic                                  memREd,
	output logic                                  reqRdy0,
	output logic                                  reqRdy1,
	output logic                                  memCmd,
	output logic [AudioDmaPkg::MemAdrsWidth-1:0]  memAdrs,
	output logic                                  smpWe0,
	output AudioDmaPkg::smpT                      smpWd0,
	output logic                                  smpWe1,
	output AudioDmaPkg::smpT                      smpWd1
);

	logic              gntVd;
	logic              stageFree;
	logic              accept0;
	logic              accept1;
	logic              tagVd;
	AudioDmaPkg::tagT  gnt;
	AudioDmaPkg::tagT  lastCh;
	AudioDmaPkg::tagT  lastNext;
	AudioDmaPkg::tagT  cmdTag;
	AudioDmaPkg::tagT  retTag;
	AudioDmaPkg::smpT  retData;

	//------------------------------------------------------------
	// Grant and command stage
	//------------------------------------------------------------
	// Stage takes a new command when empty or draining this cycle
	assign stageFree = ~memCmd | memRdy;
	assign reqRdy0 = gntVd & (gnt == 1'b0) & stageFree;
	assign reqRdy1 = gntVd & (gnt == 1'b1) & stageFree;
	assign accept0 = reqVd0 & reqRdy0;
	assign accept1 = reqVd1 & reqRdy1;
	// Channel served most recently, counting this cycle
	assign lastNext = (accept0 | accept1) ? gnt : lastCh;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			gntVd  <= 1'b0;
			gnt    <= '0;
			lastCh <= '0;
			memCmd <= 1'b0;
		end
		else
		begin
			gntVd  <= reqVd0 | reqVd1;
			lastCh <= lastNext;
			// Both asking, the other channel goes next
			if (reqVd0 && reqVd1)
				gnt <= ~lastNext;
			else
				gnt <= reqVd1;

			if (accept0 || accept1)
				memCmd <= 1'b1;
			else if (memRdy)
				memCmd <= 1'b0;
		end

		if (accept0 || accept1)
		begin
			memAdrs <= accept1 ? reqAdrs1 : reqAdrs0;
			cmdTag  <= gnt;
		end
	end

	//------------------------------------------------------------
	// Return steering
	//------------------------------------------------------------
	// Tag pushed on memory accept, popped by each returned word
	SampleFifo #(
		.payloadT (AudioDmaPkg::tagT)
	) tagFifo_i (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.wr       (memCmd & memRdy),
		.wd       (cmdTag),
		.rd       (memREd),
		.rdData   (retTag),
		.notEmpty (tagVd),
		.level    ()
	);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			smpWe0 <= 1'b0;
			smpWe1 <= 1'b0;
		end
		else
		begin
			smpWe0 <= memREd & tagVd & (retTag == 1'b0);
			smpWe1 <= memREd & tagVd & (retTag == 1'b1);
		end
		retData <= memRd;
	end

	// Same word to both, strobe picks the owner
	assign smpWd0 = retData;
	assign smpWd1 = retData;

endmodule

// ==== SampleFifo.sv ====
// Show-ahead synchronous FIFO with a type-parameter payload
// Holds audio samples per channel and read tags in the arbiter

`timescale 1ns/100ps

module SampleFifo #(
	parameter type payloadT = AudioDmaPkg::smpT
) (
	input  logic                                   iCLK,
	input  logic                                   iRST,
	input  logic                                   wr,
	input  payloadT                                wd,
	input  logic                                   rd,
	output payloadT                                rdData,
	output logic                                   notEmpty,
	output logic [AudioDmaPkg::FifoLevelWidth-1:0] level
);

	payloadT                                      mem [AudioDmaPkg::FifoDepth];
	logic [$clog2(AudioDmaPkg::FifoDepth)-1:0]    wrPtr;
	logic [$clog2(AudioDmaPkg::FifoDepth)-1:0]    rdPtr;
	logic                                         pop;

	// Pop only a valid head
	assign pop = rd & notEmpty;
	assign notEmpty = level != '0;
	// Head comes straight from the flop array, valid a cycle after its write
	assign rdData = mem[rdPtr];

	// Storage, no reset
	always_ff @(posedge iCLK)
	begin
		if (wr)
			mem[wrPtr] <= wd;
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (wr)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({wr, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build the audio DMA testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbAudioDma \
	-f verilog.f -o simAudioDma
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simAudioDma > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	exit 0
fi
exit 1

// ==== tbAudioDma.sv ====
// Testbench for the two-channel audio playback DMA
// Host tasks program the channels, random sinks pop, assertions check the streams

`timescale 1ns/100ps

module tbAudioDma;

	localparam int AdrsW = AudioDmaPkg::MemAdrsWidth;
	// Buffers far apart so the address range tells the channel
	localparam logic [AdrsW-1:0] Ch0Start = 19'h00100;
	localparam int Ch0Len = 5;
	localparam logic [AdrsW-1:0] Ch1Start = 19'h40000;
	localparam int Ch1Len = 7;
	localparam logic [31:0] LenMask = 32'h0007_FFFF;
	localparam int WaitLimit = 5000;

	logic iCLK = 1'b0;
	logic iRST = 1'b1;
	logic wbCyc = 1'b0;
	logic wbStb = 1'b0;
	logic wbWe = 1'b0;
	logic [AudioDmaPkg::WbAdrsWidth-1:0] wbAdr = '0;
	logic [AudioDmaPkg::WbDataWidth-1:0] wbDatW = '0;
	logic [AudioDmaPkg::WbDataWidth-1:0] wbDatR;
	logic wbAck;
	logic memCmd;
	logic [AdrsW-1:0] memAdrs;
	logic memRdy;
	AudioDmaPkg::smpT memRd;
	logic memREd;
	AudioDmaPkg::smpT smpRd0;
	AudioDmaPkg::smpT smpRd1;
	logic smpVd0;
	logic smpVd1;
	logic smpRe0 = 1'b0;
	logic smpRe1 = 1'b0;

	// Test phase controls
	logic popEn0 = 1'b1;
	logic noDma = 1'b1;
	logic ch0Off = 1'b0;
	// Pops and memory accepts per channel
	int popCount0 = 0;
	int popCount1 = 0;
	int cmdCount0 = 0;
	int cmdCount1 = 0;
	int mmCount = 0;
	int otherCount = 0;

	always #2 iCLK = ~iCLK;

	AudioDmaSubsystem dut_i (
		.iCLK (iCLK), .iRST (iRST),
		.wbCyc (wbCyc), .wbStb (wbStb), .wbWe (wbWe), .wbAdr (wbAdr),
		.wbDatW (wbDatW), .wbDatR (wbDatR), .wbAck (wbAck),
		.memCmd (memCmd), .memAdrs (memAdrs), .memRdy (memRdy),
		.memRd (memRd), .memREd (memREd),
		.smpRd0 (smpRd0), .smpVd0 (smpVd0), .smpRe0 (smpRe0),
		.smpRd1 (smpRd1), .smpVd1 (smpVd1), .smpRe1 (smpRe1)
	);

	tbMemModel mem_i (
		.iCLK (iCLK), .iRST (iRST), .memCmd (memCmd), .memAdrs (memAdrs),
		.memRdy (memRdy), .memRd (memRd), .memREd (memREd)
	);

	// Expected sample for the n-th pop of a looping buffer
	function automatic AudioDmaPkg::smpT expSample(input logic [AdrsW-1:0] start,
		input int len, input int count);
		logic [AdrsW-1:0] adrs;
		adrs = start + AdrsW'(count % len);
		return adrs[15:0] ^ 16'h5A3C;
	endfunction

	function automatic bit inRange(input logic [AdrsW-1:0] adrs,
		input logic [AdrsW-1:0] start, input int len);
		return (adrs >= start) && (adrs < start + AdrsW'(len));
	endfunction

	//------------------------------------------------------------
	// Sinks and bookkeeping
	//------------------------------------------------------------
	always @(posedge iCLK)
	begin
		smpRe0 <= popEn0 & ($urandom_range(0, 1) == 1);
		smpRe1 <= ($urandom_range(0, 1) == 1);
		if (smpVd0 && smpRe0)
			popCount0 <= popCount0 + 1;
		if (smpVd1 && smpRe1)
			popCount1 <= popCount1 + 1;
		// Commands counted as the memory takes them
		if (memCmd && memRdy && inRange(memAdrs, Ch0Start, Ch0Len))
			cmdCount0 <= cmdCount0 + 1;
		if (memCmd && memRdy && inRange(memAdrs, Ch1Start, Ch1Len))
			cmdCount1 <= cmdCount1 + 1;
	end

	//------------------------------------------------------------
	// Assertions
	//------------------------------------------------------------
	sampleCheck0: assert property (@(posedge iCLK) disable iff (iRST)
		(smpVd0 && smpRe0) |-> (smpRd0 == expSample(Ch0Start, Ch0Len, popCount0)))
	else
	begin
		mmCount++;
		$display("MISMATCH at %0t: channel 0 sample breaks its address sequence", $time);
	end

	sampleCheck1: assert property (@(posedge iCLK) disable iff (iRST)
		(smpVd1 && smpRe1) |-> (smpRd1 == expSample(Ch1Start, Ch1Len, popCount1)))
	else
	begin
		mmCount++;
		$display("MISMATCH at %0t: channel 1 sample breaks its address sequence", $time);
	end

	// Reads taken beyond pops never exceed the FIFO credit
	creditCheck0: assert property (@(posedge iCLK) disable iff (iRST)
		(cmdCount0 - popCount0) <= AudioDmaPkg::FifoDepth)
	else
	begin
		otherCount++;
		$display("At %0t channel 0 has more reads in flight than its FIFO can hold", $time);
	end

	creditCheck1: assert property (@(posedge iCLK) disable iff (iRST)
		(cmdCount1 - popCount1) <= AudioDmaPkg::FifoDepth)
	else
	begin
		otherCount++;
		$display("At %0t channel 1 has more reads in flight than its FIFO can hold", $time);
	end

	idleCheck: assert property (@(posedge iCLK) disable iff (iRST)
		noDma |-> (!memCmd && !smpVd0 && !smpVd1))
	else
	begin
		otherCount++;
		$display("At %0t a memory command or sample appeared with both channels off", $time);
	end

	// One ack per strobe and only inside a cycle
	ackCheck: assert property (@(posedge iCLK) disable iff (iRST)
		wbAck |-> ($past(wbCyc && wbStb) && !$past(wbAck)))
	else
	begin
		otherCount++;
		$display("At %0t the Wishbone ack came without a strobe or lasted too long", $time);
	end

	offCheck: assert property (@(posedge iCLK) disable iff (iRST)
		ch0Off |-> !(memCmd && memRdy && inRange(memAdrs, Ch0Start, Ch0Len)))
	else
	begin
		otherCount++;
		$display("At %0t channel 0 issued a read after it was disabled", $time);
	end

	//------------------------------------------------------------
	// Host tasks
	//------------------------------------------------------------
	task automatic reportTimeout(input string what);
		otherCount++;
		$display("Timeout at %0t while waiting for %s", $time, what);
	endtask

	// Called on a clock edge and returns on the ack edge
	task automatic wbAccess(input logic we, input logic [2:0] adrs,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		wbCyc  <= 1'b1;
		wbStb  <= 1'b1;
		wbWe   <= we;
		wbAdr  <= adrs;
		wbDatW <= wdata;
		n = 0;
		@(posedge iCLK);
		while (!wbAck && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (!wbAck)
			reportTimeout("a Wishbone ack");
		rdata = wbDatR;
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
	endtask

	task automatic checkReg(input logic [2:0] adrs, input logic [31:0] value,
		input logic [31:0] mask);
		logic [31:0] rdVal;
		wbAccess(1'b1, adrs, value, rdVal);
		wbAccess(1'b0, adrs, '0, rdVal);
		assert (rdVal == (value & mask))
		else
		begin
			mmCount++;
			$display("MISMATCH at %0t: register %0d read %h, wrote %h", $time, adrs, rdVal, value);
		end
	endtask

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial
	begin
		logic [31:0] rdVal;
		int n;
		int mark0;
		int mark1;

		void'($urandom(32'h473f));
		repeat (2) @(posedge iCLK);
		iRST <= 1'b0;
		@(posedge iCLK);
		assert (!wbAck && !memCmd && !smpVd0 && !smpVd1)
		else
		begin
			otherCount++;
			$display("At %0t an output was already active after reset", $time);
		end
		// Quiet window with both enables clear
		repeat (20) @(posedge iCLK);

		// Register read-back with both enables kept clear
		checkReg(AudioDmaPkg::RegStart0, $urandom(), LenMask);
		checkReg(AudioDmaPkg::RegLen0, $urandom(), LenMask);
		checkReg(AudioDmaPkg::RegStart1, $urandom(), LenMask);
		checkReg(AudioDmaPkg::RegLen1, $urandom(), LenMask);
		checkReg(AudioDmaPkg::RegCtrl, 32'hFFFF_FFFC, 32'h3);
		wbAccess(1'b0, 3'd7, '0, rdVal);
		assert (rdVal == '0)
		else
		begin
			mmCount++;
			$display("MISMATCH at %0t: unmapped address 7 read %h", $time, rdVal);
		end

		// Channel 0 alone for at least two passes
		checkReg(AudioDmaPkg::RegStart0, Ch0Start, LenMask);
		checkReg(AudioDmaPkg::RegLen0, Ch0Len, LenMask);
		noDma <= 1'b0;
		checkReg(AudioDmaPkg::RegCtrl, 32'h1, 32'h3);
		n = 0;
		while (popCount0 < 3 * Ch0Len && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (popCount0 < 3 * Ch0Len)
			reportTimeout("channel 0 samples");

		// Both channels under memory stalls
		checkReg(AudioDmaPkg::RegStart1, Ch1Start, LenMask);
		checkReg(AudioDmaPkg::RegLen1, Ch1Len, LenMask);
		checkReg(AudioDmaPkg::RegCtrl, 32'h3, 32'h3);
		mark0 = popCount0;
		n = 0;
		while ((popCount1 < 2 * Ch1Len || popCount0 < mark0 + 10) && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (popCount1 < 2 * Ch1Len || popCount0 < mark0 + 10)
			reportTimeout("samples from both channels");

		// Sink 0 stalls until its FIFO fills and credit holds
		popEn0 <= 1'b0;
		repeat (100) @(posedge iCLK);
		popEn0 <= 1'b1;
		mark0 = popCount0;
		n = 0;
		while (popCount0 < mark0 + 2 * AudioDmaPkg::FifoDepth && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (popCount0 < mark0 + 2 * AudioDmaPkg::FifoDepth)
			reportTimeout("channel 0 to resume after the stall");

		// Channel 0 off while channel 1 keeps going
		wbAccess(1'b1, AudioDmaPkg::RegCtrl, 32'h2, rdVal);
		repeat (2) @(posedge iCLK);
		// A last command may still sit in the arbiter stage
		n = 0;
		while (memCmd && inRange(memAdrs, Ch0Start, Ch0Len) && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (memCmd && inRange(memAdrs, Ch0Start, Ch0Len))
			reportTimeout("the last channel 0 command to leave the arbiter");
		ch0Off <= 1'b1;
		n = 0;
		while ((popCount0 != cmdCount0 || smpVd0) && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (popCount0 != cmdCount0 || smpVd0)
			reportTimeout("channel 0 to drain");
		mark0 = popCount0;
		mark1 = popCount1;
		n = 0;
		while (popCount1 < mark1 + 20 && n < WaitLimit)
		begin
			@(posedge iCLK);
			n++;
		end
		if (popCount1 < mark1 + 20)
			reportTimeout("channel 1 samples after channel 0 stopped");
		assert (popCount0 == mark0 && !smpVd0)
		else
		begin
			otherCount++;
			$display("At %0t channel 0 kept delivering samples after it drained", $time);
		end

		$display("Errors: %0d mismatches, %0d other failures", mmCount, otherCount);
		if (mmCount == 0 && otherCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== tbMemModel.sv ====
// Memory model for the audio DMA testbench
// Random command stalls, in-order read data after 1 to 6 cycles

`timescale 1ns/100ps

module tbMemModel (
	input  logic                                 iCLK,
	input  logic                                 iRST,
	input  logic                                 memCmd,
	input  logic [AudioDmaPkg::MemAdrsWidth-1:0] memAdrs,
	output logic                                 memRdy,
	output AudioDmaPkg::smpT                     memRd,
	output logic                                 memREd
);

	logic                                 rdyR = 1'b0;
	logic                                 retVd = 1'b0;
	AudioDmaPkg::smpT                     retData = '0;
	// Accepted reads waiting for their return cycle
	logic [AudioDmaPkg::MemAdrsWidth-1:0] adrsQ [$];
	longint                               dueQ [$];
	longint                               cycle = 0;
	longint                               lastDue = 0;

	assign memRdy = rdyR;
	assign memRd = retData;
	assign memREd = retVd;

	always @(posedge iCLK)
	begin
		longint                               due;
		logic [AudioDmaPkg::MemAdrsWidth-1:0] rdAdrs;

		cycle = cycle + 1;
		if (iRST)
		begin
			rdyR  <= 1'b0;
			retVd <= 1'b0;
			adrsQ.delete();
			dueQ.delete();
		end
		else
		begin
			// Ready about three cycles in four
			rdyR <= ($urandom_range(0, 3) != 0);

			if (memCmd && memRdy)
			begin
				due = cycle + $urandom_range(1, 6);
				// Keep returns in order, one per cycle
				if (due <= lastDue)
					due = lastDue + 1;
				lastDue = due;
				adrsQ.push_back(memAdrs);
				dueQ.push_back(due);
			end

			retVd <= 1'b0;
			if (dueQ.size() != 0 && dueQ[0] <= cycle)
			begin
				rdAdrs = adrsQ.pop_front();
				void'(dueQ.pop_front());
				retVd   <= 1'b1;
				// Data rule: low address bits xor a fixed pattern
				retData <= rdAdrs[15:0] ^ 16'h5A3C;
			end
		end
	end

endmodule

// ==== verilog.f ====
AudioDmaPkg.sv
SampleFifo.sv
DmaRegDecode.sv
AudioDmaUnit.sv
MemPortArbiter.sv
AudioDmaSubsystem.sv
tbMemModel.sv
tbAudioDma.sv
